/* flist.f */
src/ts_pkg.sv
src/ts_if.sv
src/ts_packet_tracker.sv
src/ts_reg_bank.sv
src/ts_pid_monitor.sv
src/ts_pid_replacer.sv
src/ts_filter_top.sv
test/ts_filter_chk.sv
test/ts_filter_tb.sv

/* Bender.yml */
package:
  name: ts_filter

sources:
  - src/ts_pkg.sv
  - src/ts_if.sv
  - src/ts_packet_tracker.sv
  - src/ts_reg_bank.sv
  - src/ts_pid_monitor.sv
  - src/ts_pid_replacer.sv
  - src/ts_filter_top.sv
  - target: test
    files:
      - test/ts_filter_chk.sv
      - test/ts_filter_tb.sv

/* test/ts_filter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_filter_tb;
	import ts_pkg::*;

	localparam logic [31:0] lcg_seed = 32'h6db9;
	localparam int cycles_per_row = 200;
	localparam logic [2:0] op_write = 3'd0;
	localparam logic [2:0] op_read = 3'd1;
	localparam logic [2:0] op_packet = 3'd2;
	localparam logic [2:0] op_fill = 3'd3;
	localparam logic [2:0] op_window = 3'd4;

	typedef struct packed {
		logic [2:0]  op;
		logic [7:0]  addr;
		logic [3:0]  strb;
		logic [31:0] value;
	} row_t;

	logic        clk;
	logic        rst_n;
	logic        wen;
	logic [3:0]  wstrb;
	logic [7:0]  waddr;
	logic [31:0] wdata;
	logic        ren;
	logic [7:0]  raddr;
	logic [31:0] rdata;
	logic [7:0]  mpeg_data;
	logic        mpeg_valid;
	logic        mpeg_sync;
	logic [7:0]  ts_out;
	logic        ts_out_valid;
	logic        ts_out_sync;

	row_t rows [$];
	bit   table_ready;
	int   cycle;
	int   checks;
	int   errors;

	// expected output bytes, oldest first
	logic [7:0] exp_data [$];
	logic       exp_sync [$];
	int         exp_due [$];

	// reference model of the register state
	logic [1:0]  ref_slot;
	logic [12:0] ref_pid [0:2];
	logic        ref_en [0:2];
	logic [31:0] ref_buf [1:2][0:45];
	logic        ref_armed;
	logic [7:0]  cap_bytes [0:187];
	logic [3:0]  cc;

	ts_filter_top ts_filter_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expect_value);
		checks++;
		assert (got === expect_value) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got,
				expect_value);
		end
	endtask

	task automatic check_true(bit ok, string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERROR at %0t: %s", $time, what);
		end
	endtask

	// one clock, outputs compared at the falling edge
	task automatic step();
		@(negedge clk);
		cycle++;
		if (ts_out_valid) begin
			check_true(exp_data.size() > 0, "output byte appeared with none expected");
			if (exp_data.size() > 0) begin
				check_value("ts_out", ts_out, exp_data.pop_front());
				check_value("ts_out_sync", ts_out_sync, exp_sync.pop_front());
				check_value("ts_out cycle", cycle, exp_due.pop_front());
			end
		end else if (exp_data.size() > 0 && exp_due[0] <= cycle) begin
			check_true(1'b0, "expected output byte did not appear");
			void'(exp_data.pop_front());
			void'(exp_sync.pop_front());
			void'(exp_due.pop_front());
		end
	endtask

	task automatic write_reg(logic [7:0] addr, logic [3:0] strb, logic [31:0] value);
		int w;
		int b;
		step();
		wen = 1'b1;
		waddr = addr;
		wstrb = strb;
		wdata = value;
		step();
		wen = 1'b0;
		step();
		w = int'(addr) - reg_data_base;
		if (addr == reg_slot) begin
			if (value < num_slots) begin
				ref_slot = value[1:0];
			end
		end else if (addr == reg_pid) begin
			ref_pid[ref_slot] = value[12:0];
		end else if (addr == reg_enable) begin
			ref_en[ref_slot] = value[0];
		end else if (addr == reg_capture) begin
			if (ref_slot == 2'd0) begin
				ref_armed = 1'b1;
			end
		end else if (w >= 0 && w < ts_payload_words && ref_slot != 2'd0) begin
			for (b = 0; b < 4; b++) begin
				if (strb[b]) begin
					ref_buf[ref_slot][w][8*b +: 8] = value[8*b +: 8];
				end
			end
		end
	endtask

	task automatic read_reg(logic [7:0] addr, logic [31:0] expect_value);
		step();
		ren = 1'b1;
		raddr = addr;
		step();
		ren = 1'b0;
		check_value($sformatf("rdata (raddr %0d)", addr), rdata, expect_value);
	endtask

	task automatic fill_window(logic [31:0] base);
		int w;
		for (w = 0; w < ts_payload_words; w++) begin
			write_reg(8'(reg_data_base + w), 4'hF, lcg_next(base ^ w));
		end
	endtask

	task automatic check_window();
		int w;
		logic [31:0] expect_word;
		if (ref_slot == 2'd0) begin
			for (w = 0; w < ts_packet_words; w++) begin
				expect_word = {cap_bytes[4*w+3], cap_bytes[4*w+2], cap_bytes[4*w+1],
					cap_bytes[4*w]};
				read_reg(8'(reg_data_base + w), expect_word);
			end
		end else begin
			for (w = 0; w < ts_payload_words; w++) begin
				read_reg(8'(reg_data_base + w), ref_buf[ref_slot][w]);
			end
		end
	endtask

	task automatic send_packet(logic [12:0] pid, logic [15:0] salt);
		logic [7:0]  pkt [0:187];
		logic [31:0] state;
		logic [7:0]  expect_byte;
		logic        hit1;
		logic        hit2;
		int          i;
		int          p;
		state = lcg_seed ^ {16'd0, salt};
		pkt[0] = 8'h47;
		pkt[1] = {3'b010, pid[12:8]};
		pkt[2] = pid[7:0];
		pkt[3] = {4'b0001, cc};
		cc++;
		for (i = 4; i < 188; i++) begin
			state = lcg_next(state);
			pkt[i] = state[23:16];
		end
		hit1 = ref_en[1] && ref_pid[1] == pid;
		hit2 = ref_en[2] && ref_pid[2] == pid;
		if (ref_armed && ref_en[0] && ref_pid[0] == pid) begin
			for (i = 0; i < 188; i++) begin
				cap_bytes[i] = pkt[i];
			end
			ref_armed = 1'b0;
		end
		for (i = 0; i < 188; i++) begin
			p = i - 4;
			expect_byte = pkt[i];
			// replacer 2 is last in the chain
			if (i >= 4 && hit2) begin
				expect_byte = ref_buf[2][p / 4][8 * (p % 4) +: 8];
			end else if (i >= 4 && hit1) begin
				expect_byte = ref_buf[1][p / 4][8 * (p % 4) +: 8];
			end
			step();
			mpeg_data = pkt[i];
			mpeg_valid = 1'b1;
			mpeg_sync = (i == 0);
			exp_data.push_back(expect_byte);
			exp_sync.push_back(i == 0);
			exp_due.push_back(cycle + ts_stream_latency);
		end
		step();
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		repeat (3) step();
	endtask

	function automatic void table_row(logic [2:0] op, logic [7:0] addr, logic [3:0] strb,
		logic [31:0] value);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.strb = strb;
		r.value = value;
		rows.push_back(r);
	endfunction

	// packet rows carry the salt in the upper half and the PID below
	function automatic void build_table();
		table_row(op_read, 0, 4'hF, 0);
		table_row(op_read, 1, 4'hF, 0);
		table_row(op_read, 2, 4'hF, 0);
		table_row(op_read, 3, 4'hF, 0);
		table_row(op_write, 0, 4'hF, 2);
		table_row(op_read, 0, 4'hF, 2);
		table_row(op_write, 0, 4'hF, 5);
		table_row(op_read, 0, 4'hF, 2);
		table_row(op_write, 0, 4'hF, 3);
		table_row(op_read, 0, 4'hF, 2);
		table_row(op_write, 1, 4'hF, 32'hABCD_F0F0);
		table_row(op_read, 1, 4'hF, 32'h0000_10F0);
		table_row(op_read, 4, 4'hF, 32'hE000_0004);
		table_row(op_read, 127, 4'hF, 32'hE000_007F);
		table_row(op_read, 200, 4'hF, 32'hE000_00C8);
		table_row(op_write, 0, 4'hF, 1);
		table_row(op_read, 174, 4'hF, 32'hE000_00AE);
		table_row(op_read, 0, 4'hF, 1);
		// pass-through with nothing enabled
		table_row(op_write, 1, 4'hF, 32'h100);
		table_row(op_write, 0, 4'hF, 2);
		table_row(op_write, 1, 4'hF, 32'h200);
		table_row(op_packet, 0, 4'h0, {16'd1, 16'h0100});
		table_row(op_packet, 0, 4'h0, {16'd2, 16'h0055});
		table_row(op_write, 0, 4'hF, 1);
		table_row(op_fill, 0, 4'hF, 32'h1111);
		table_row(op_write, 133, 4'b0101, 32'hA5C3_5A3C);
		table_row(op_write, 2, 4'hF, 1);
		table_row(op_window, 0, 4'h0, 0);
		table_row(op_packet, 0, 4'h0, {16'd3, 16'h0100});
		table_row(op_packet, 0, 4'h0, {16'd4, 16'h0200});
		table_row(op_write, 0, 4'hF, 2);
		table_row(op_fill, 0, 4'hF, 32'h2222);
		table_row(op_write, 2, 4'hF, 1);
		table_row(op_window, 0, 4'h0, 0);
		table_row(op_packet, 0, 4'h0, {16'd5, 16'h0200});
		// both replacers on one PID
		table_row(op_write, 1, 4'hF, 32'h100);
		table_row(op_packet, 0, 4'h0, {16'd6, 16'h0100});
		table_row(op_write, 2, 4'hF, 0);
		table_row(op_write, 0, 4'hF, 1);
		table_row(op_write, 2, 4'hF, 0);
		table_row(op_packet, 0, 4'h0, {16'd7, 16'h0100});
		// monitor capture
		table_row(op_write, 0, 4'hF, 0);
		table_row(op_write, 1, 4'hF, 32'h321);
		table_row(op_write, 2, 4'hF, 1);
		table_row(op_read, 1, 4'hF, 32'h321);
		table_row(op_write, 3, 4'hF, 0);
		table_row(op_read, 3, 4'hF, 0);
		table_row(op_packet, 0, 4'h0, {16'd8, 16'h0100});
		table_row(op_read, 3, 4'hF, 0);
		table_row(op_packet, 0, 4'h0, {16'd9, 16'h0321});
		table_row(op_read, 3, 4'hF, 1);
		table_row(op_window, 0, 4'h0, 0);
		table_row(op_packet, 0, 4'h0, {16'd10, 16'h0321});
		table_row(op_window, 0, 4'h0, 0);
		table_row(op_read, 3, 4'hF, 1);
	endfunction

	initial begin
		int   i;
		row_t r;
		rst_n = 1'b0;
		wen = 1'b0;
		wstrb = 4'h0;
		waddr = 8'h00;
		wdata = 32'h0;
		ren = 1'b0;
		raddr = 8'h00;
		mpeg_data = 8'h00;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		cycle = 0;
		checks = 0;
		errors = 0;
		cc = 4'd0;
		ref_slot = 2'd0;
		ref_armed = 1'b0;
		for (i = 0; i < 3; i++) begin
			ref_pid[i] = 13'd0;
			ref_en[i] = 1'b0;
		end
		build_table();
		table_ready = 1'b1;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		for (i = 0; i < rows.size(); i++) begin
			r = rows[i];
			case (r.op)
				op_write: write_reg(r.addr, r.strb, r.value);
				op_read: read_reg(r.addr, r.value);
				op_packet: send_packet(r.value[12:0], r.value[31:16]);
				op_fill: fill_window(r.value);
				default: check_window();
			endcase
		end
		repeat (6) step();
		check_true(exp_data.size() == 0, "output bytes still missing at the end of the run");
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			ts_filter_top_inst.ts_filter_chk_inst.fail_count);
		if (errors == 0 && ts_filter_top_inst.ts_filter_chk_inst.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog scaled to the table length
	initial begin
		wait (table_ready);
		repeat (rows.size() * cycles_per_row) @(posedge clk);
		$display("ERROR: watchdog expired, the run did not finish in time");
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* test/ts_filter_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_filter_chk (
	input logic clk,
	input logic rst_n,
	input logic mpeg_valid,
	input logic ts_out_valid,
	input logic ts_out_sync
);

	int fail_count = 0;

	// three register stages from input to output
	valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		ts_out_valid == $past(mpeg_valid, 3))
	else begin
		fail_count++;
		$error("ts_out_valid does not follow mpeg_valid by three cycles");
	end

	sync_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		ts_out_sync |-> ts_out_valid)
	else begin
		fail_count++;
		$error("ts_out_sync seen without ts_out_valid");
	end

	valid_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ts_out_valid)
	else begin
		fail_count++;
		$error("ts_out_valid high in the cycle after reset");
	end

endmodule

bind ts_filter_top ts_filter_chk ts_filter_chk_inst (
	.clk          (clk),
	.rst_n        (rst_n),
	.mpeg_valid   (mpeg_valid),
	.ts_out_valid (ts_out_valid),
	.ts_out_sync  (ts_out_sync)
);

`default_nettype wire

/* src/ts_filter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_filter_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wen,
	input  logic [3:0]                    wstrb,
	input  logic [ts_pkg::reg_addr_w-1:0] waddr,
	input  logic [31:0]                   wdata,
	input  logic                          ren,
	input  logic [ts_pkg::reg_addr_w-1:0] raddr,
	output logic [31:0]                   rdata,
	input  logic [7:0]                    mpeg_data,
	input  logic                          mpeg_valid,
	input  logic                          mpeg_sync,
	output logic [7:0]                    ts_out,
	output logic                          ts_out_valid,
	output logic                          ts_out_sync
);

	filter_cfg_if mon_cfg ();
	filter_cfg_if rep1_cfg ();
	filter_cfg_if rep2_cfg ();

	ts_stream_if trk_stream ();
	ts_stream_if mid_stream ();
	ts_stream_if out_stream ();

	ts_packet_tracker tracker (
		.clk        (clk),
		.rst_n      (rst_n),
		.mpeg_data  (mpeg_data),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync  (mpeg_sync),
		.stream     (trk_stream)
	);

	ts_reg_bank reg_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.wen      (wen),
		.wstrb    (wstrb),
		.waddr    (waddr),
		.wdata    (wdata),
		.ren      (ren),
		.raddr    (raddr),
		.rdata    (rdata),
		.mon_cfg  (mon_cfg),
		.rep1_cfg (rep1_cfg),
		.rep2_cfg (rep2_cfg)
	);

	ts_pid_monitor monitor (
		.clk    (clk),
		.rst_n  (rst_n),
		.stream (trk_stream),
		.cfg    (mon_cfg)
	);

	ts_pid_replacer replacer_1 (
		.clk        (clk),
		.rst_n      (rst_n),
		.stream_in  (trk_stream),
		.stream_out (mid_stream),
		.cfg        (rep1_cfg)
	);

	// last in the chain, so its bytes win
	ts_pid_replacer replacer_2 (
		.clk        (clk),
		.rst_n      (rst_n),
		.stream_in  (mid_stream),
		.stream_out (out_stream),
		.cfg        (rep2_cfg)
	);

	assign ts_out = out_stream.data;
	assign ts_out_valid = out_stream.valid;
	assign ts_out_sync = out_stream.sync;

endmodule

`default_nettype wire

/* src/ts_pid_replacer.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_pid_replacer (
	input  logic         clk,
	input  logic         rst_n,
	ts_stream_if.sink    stream_in,
	ts_stream_if.source  stream_out,
	filter_cfg_if.filter cfg
);
	import ts_pkg::*;

	logic [31:0] payload_mem [0:ts_payload_words-1];
	logic [12:0] pid;
	logic        enable;
	logic        match;
	logic        replace;
	logic [7:0]  payload_pos;
	logic [31:0] sub_word;
	logic [7:0]  sub_byte;

	assign cfg.pid = pid;
	assign cfg.enable = enable;
	assign cfg.rd_word = payload_mem[cfg.rd_index];
	assign cfg.capture_done = 1'b0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pid <= 13'd0;
			enable <= 1'b0;
		end else begin
			if (cfg.wr_pid) begin
				pid <= cfg.wr_word[12:0];
			end
			if (cfg.wr_enable) begin
				enable <= cfg.wr_word[0];
			end
		end
	end

	// byte-strobed buffer write
	always_ff @(posedge clk) begin
		if (cfg.wr_data) begin
			for (int b = 0; b < 4; b++) begin
				if (cfg.wr_strb[b]) begin
					payload_mem[cfg.wr_index][8*b +: 8] <= cfg.wr_word[8*b +: 8];
				end
			end
		end
	end

	// match holds for the rest of the packet
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			match <= 1'b0;
		end else if (stream_in.valid) begin
			if (stream_in.sync) begin
				match <= 1'b0;
			end else if (stream_in.header_done
				&& stream_in.byte_index == 8'(ts_header_bytes - 1)) begin
				match <= enable && stream_in.header.fields.pid == pid;
			end
		end
	end

	assign payload_pos = stream_in.byte_index - 8'(ts_header_bytes);
	assign sub_word = payload_mem[payload_pos[7:2]];
	assign sub_byte = sub_word[8*payload_pos[1:0] +: 8];
	assign replace = match && stream_in.valid
		&& stream_in.byte_index >= 8'(ts_header_bytes);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stream_out.valid <= 1'b0;
			stream_out.sync <= 1'b0;
			stream_out.header_done <= 1'b0;
		end else begin
			stream_out.valid <= stream_in.valid;
			stream_out.sync <= stream_in.sync;
			stream_out.header_done <= stream_in.header_done;
		end
	end

	// position and header travel with the byte
	always_ff @(posedge clk) begin
		stream_out.data <= replace ? sub_byte : stream_in.data;
		stream_out.byte_index <= stream_in.byte_index;
		stream_out.header <= stream_in.header;
	end

endmodule

`default_nettype wire

/* src/ts_pid_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_pid_monitor (
	input  logic         clk,
	input  logic         rst_n,
	ts_stream_if.sink    stream,
	filter_cfg_if.filter cfg
);
	import ts_pkg::*;

	logic [31:0] capture_mem [0:ts_packet_words-1];
	logic [12:0] pid;
	logic        enable;
	logic        armed;
	logic        capturing;
	logic        capture_done;
	logic        header_hit;
	logic        last_byte;

	assign cfg.pid = pid;
	assign cfg.enable = enable;
	assign cfg.rd_word = capture_mem[cfg.rd_index];
	assign cfg.capture_done = capture_done;

	// decision taken on the last header byte
	assign header_hit = stream.valid && stream.header_done
		&& stream.byte_index == 8'(ts_header_bytes - 1)
		&& armed && enable && stream.header.fields.pid == pid;
	assign last_byte = stream.valid && capturing
		&& stream.byte_index == 8'(ts_packet_bytes - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pid <= 13'd0;
			enable <= 1'b0;
			armed <= 1'b0;
			capturing <= 1'b0;
			capture_done <= 1'b0;
		end else begin
			if (cfg.wr_pid) begin
				pid <= cfg.wr_word[12:0];
			end
			if (cfg.wr_enable) begin
				enable <= cfg.wr_word[0];
			end
			if (cfg.capture_req) begin
				armed <= 1'b1;
				capturing <= 1'b0;
				capture_done <= 1'b0;
			end else if (header_hit) begin
				capturing <= 1'b1;
			end else if (last_byte) begin
				capturing <= 1'b0;
				armed <= 1'b0;
				capture_done <= 1'b1;
			end else if (stream.valid && stream.sync) begin
				// short packet, wait for the next header
				capturing <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (header_hit && !cfg.capture_req) begin
			capture_mem[0] <= {stream.header.bytes[3], stream.header.bytes[2],
				stream.header.bytes[1], stream.header.bytes[0]};
		end else if (capturing && stream.valid
			&& stream.byte_index >= 8'(ts_header_bytes)) begin
			capture_mem[stream.byte_index[7:2]][8*stream.byte_index[1:0] +: 8] <= stream.data;
		end
	end

endmodule

`default_nettype wire

/* src/ts_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_reg_bank (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          wen,
	input  logic [3:0]                    wstrb,
	input  logic [ts_pkg::reg_addr_w-1:0] waddr,
	input  logic [31:0]                   wdata,
	input  logic                          ren,
	input  logic [ts_pkg::reg_addr_w-1:0] raddr,
	output logic [31:0]                   rdata,
	filter_cfg_if.ctrl                    mon_cfg,
	filter_cfg_if.ctrl                    rep1_cfg,
	filter_cfg_if.ctrl                    rep2_cfg
);
	import ts_pkg::*;

	logic                  wen_q;
	logic [3:0]            wstrb_q;
	logic [reg_addr_w-1:0] waddr_q;
	logic [31:0]           wdata_q;
	logic [1:0]            slot;
	logic [reg_addr_w-1:0] woff;
	logic [reg_addr_w-1:0] roff;
	logic                  pid_hit;
	logic                  enable_hit;
	logic                  data_hit;
	logic                  capture_hit;
	logic [12:0]           sel_pid;
	logic                  sel_enable;
	logic [31:0]           sel_word;
	logic [reg_addr_w-1:0] win_limit;
	logic [31:0]           rd_value;

	// write is captured first, decoded one cycle later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wen_q <= 1'b0;
		end else begin
			wen_q <= wen;
		end
	end

	always_ff @(posedge clk) begin
		if (wen) begin
			wstrb_q <= wstrb;
			waddr_q <= waddr;
			wdata_q <= wdata;
		end
	end

	assign woff = waddr_q - reg_addr_w'(reg_data_base);
	assign roff = raddr - reg_addr_w'(reg_data_base);

	assign pid_hit = wen_q && waddr_q == reg_addr_w'(reg_pid);
	assign enable_hit = wen_q && waddr_q == reg_addr_w'(reg_enable);
	assign capture_hit = wen_q && waddr_q == reg_addr_w'(reg_capture);
	// only the replacer window is writable
	assign data_hit = wen_q && waddr_q >= reg_addr_w'(reg_data_base)
		&& woff < reg_addr_w'(ts_payload_words);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot <= 2'd0;
		end else if (wen_q && waddr_q == reg_addr_w'(reg_slot)) begin
			if (wdata_q < 32'(num_slots)) begin
				slot <= wdata_q[1:0];
			end
		end
	end

	assign mon_cfg.wr_pid = pid_hit && slot == 2'd0;
	assign mon_cfg.wr_enable = enable_hit && slot == 2'd0;
	assign mon_cfg.wr_data = data_hit && slot == 2'd0;
	assign mon_cfg.capture_req = capture_hit && slot == 2'd0;
	assign mon_cfg.wr_word = wdata_q;
	assign mon_cfg.wr_strb = wstrb_q;
	assign mon_cfg.wr_index = woff[word_index_w-1:0];
	assign mon_cfg.rd_index = roff[word_index_w-1:0];

	assign rep1_cfg.wr_pid = pid_hit && slot == 2'd1;
	assign rep1_cfg.wr_enable = enable_hit && slot == 2'd1;
	assign rep1_cfg.wr_data = data_hit && slot == 2'd1;
	assign rep1_cfg.capture_req = 1'b0;
	assign rep1_cfg.wr_word = wdata_q;
	assign rep1_cfg.wr_strb = wstrb_q;
	assign rep1_cfg.wr_index = woff[word_index_w-1:0];
	assign rep1_cfg.rd_index = roff[word_index_w-1:0];

	assign rep2_cfg.wr_pid = pid_hit && slot == 2'd2;
	assign rep2_cfg.wr_enable = enable_hit && slot == 2'd2;
	assign rep2_cfg.wr_data = data_hit && slot == 2'd2;
	assign rep2_cfg.capture_req = 1'b0;
	assign rep2_cfg.wr_word = wdata_q;
	assign rep2_cfg.wr_strb = wstrb_q;
	assign rep2_cfg.wr_index = woff[word_index_w-1:0];
	assign rep2_cfg.rd_index = roff[word_index_w-1:0];

	// state of the selected filter
	always_comb begin
		case (slot)
			2'd0: begin
				sel_pid = mon_cfg.pid;
				sel_enable = mon_cfg.enable;
				sel_word = mon_cfg.rd_word;
				win_limit = reg_addr_w'(ts_packet_words);
			end
			2'd1: begin
				sel_pid = rep1_cfg.pid;
				sel_enable = rep1_cfg.enable;
				sel_word = rep1_cfg.rd_word;
				win_limit = reg_addr_w'(ts_payload_words);
			end
			default: begin
				sel_pid = rep2_cfg.pid;
				sel_enable = rep2_cfg.enable;
				sel_word = rep2_cfg.rd_word;
				win_limit = reg_addr_w'(ts_payload_words);
			end
		endcase
	end

	always_comb begin
		rd_value = unmapped_tag | 32'(raddr);
		case (raddr)
			reg_addr_w'(reg_slot): rd_value = 32'(slot);
			reg_addr_w'(reg_pid): rd_value = 32'(sel_pid);
			reg_addr_w'(reg_enable): rd_value = 32'(sel_enable);
			reg_addr_w'(reg_capture): rd_value = 32'(slot == 2'd0 && mon_cfg.capture_done);
			default: begin
				if (raddr >= reg_addr_w'(reg_data_base) && roff < win_limit) begin
					rd_value = sel_word;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= 32'd0;
		end else if (ren) begin
			rdata <= rd_value;
		end
	end

endmodule

`default_nettype wire

/* src/ts_packet_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module ts_packet_tracker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  mpeg_data,
	input  logic        mpeg_valid,
	input  logic        mpeg_sync,
	ts_stream_if.source stream
);
	import ts_pkg::*;

	logic       active;
	logic       take;
	logic [7:0] next_index;

	// nothing is counted before the first sync
	assign take = mpeg_valid && (mpeg_sync || active);

	// index of the incoming byte, parks at the last byte
	always_comb begin
		if (mpeg_sync) begin
			next_index = 8'd0;
		end else if (stream.byte_index < 8'(ts_packet_bytes - 1)) begin
			next_index = stream.byte_index + 8'd1;
		end else begin
			next_index = stream.byte_index;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			stream.valid <= 1'b0;
			stream.sync <= 1'b0;
			stream.byte_index <= 8'd0;
			stream.header_done <= 1'b0;
		end else begin
			stream.valid <= mpeg_valid;
			stream.sync <= mpeg_valid && mpeg_sync;
			if (take) begin
				active <= 1'b1;
				stream.byte_index <= next_index;
				if (next_index == 8'(ts_header_bytes - 1)) begin
					stream.header_done <= 1'b1;
				end else if (next_index == 8'd0) begin
					stream.header_done <= 1'b0;
				end
			end
		end
	end

	// header is complete in the same cycle as byte 3
	always_ff @(posedge clk) begin
		stream.data <= mpeg_data;
		if (take && next_index < 8'(ts_header_bytes)) begin
			stream.header.bytes[next_index[1:0]] <= mpeg_data;
		end
	end

endmodule

`default_nettype wire

/* src/ts_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ts_stream_if;
	import ts_pkg::*;

	logic [7:0] data;
	logic       valid;
	logic       sync;
	logic [7:0] byte_index;
	ts_header_u header;
	logic       header_done;

	modport source (
		output data,
		output valid,
		output sync,
		output byte_index,
		output header,
		output header_done
	);

	modport sink (
		input data,
		input valid,
		input sync,
		input byte_index,
		input header,
		input header_done
	);
endinterface

interface filter_cfg_if;
	import ts_pkg::*;

	// one-cycle strobes from the register bank
	logic                    wr_pid;
	logic                    wr_enable;
	logic                    wr_data;
	logic                    capture_req;
	logic [31:0]             wr_word;
	logic [3:0]              wr_strb;
	logic [word_index_w-1:0] wr_index;
	logic [word_index_w-1:0] rd_index;

	// state held by the filter
	logic [12:0]             pid;
	logic                    enable;
	logic [31:0]             rd_word;
	logic                    capture_done;

	modport ctrl (
		output wr_pid, wr_enable, wr_data, capture_req,
		output wr_word, wr_strb, wr_index, rd_index,
		input  pid, enable, rd_word, capture_done
	);

	modport filter (
		input  wr_pid, wr_enable, wr_data, capture_req,
		input  wr_word, wr_strb, wr_index, rd_index,
		output pid, enable, rd_word, capture_done
	);
endinterface

`default_nettype wire

/* src/ts_pkg.sv */
`default_nettype none

package ts_pkg;

	// stream framing
	localparam int ts_packet_bytes = 188;
	localparam int ts_header_bytes = 4;
	localparam logic [7:0] ts_sync_byte = 8'h47;
	localparam int ts_payload_words = 46;
	localparam int ts_packet_words = 47;
	localparam int ts_stream_latency = 3;

	// register map, word addresses
	localparam int reg_slot = 0;
	localparam int reg_pid = 1;
	localparam int reg_enable = 2;
	localparam int reg_capture = 3;
	localparam int reg_data_base = 128;
	localparam int num_slots = 3;
	localparam logic [31:0] unmapped_tag = 32'hE000_0000;

	localparam int reg_addr_w = 8;
	localparam int word_index_w = 6;

	// field order follows the wire order, sync byte on top
	typedef struct packed {
		logic [7:0]  sync;
		logic        tei;
		logic        pusi;
		logic        prio;
		logic [12:0] pid;
		logic [1:0]  scrambling;
		logic [1:0]  afc;
		logic [3:0]  cc;
	} ts_header_s;

	// bytes[0] is the sync byte
	typedef union packed {
		logic [0:3][7:0] bytes;
		ts_header_s      fields;
	} ts_header_u;

endpackage

`default_nettype wire
